// File: sim.f
hdl/decoder_pkg.sv
hdl/decoder_regs.sv
hdl/biphase_to_nrz.sv
hdl/mark_space_decode.sv
hdl/symbol_demux.sv
hdl/bit_output_stage.sv
hdl/decoder.sv
testbench/decoder_tb.sv

// File: Makefile
# Verilator simulation of the bit decoder testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f sim.f --top-module decoder_tb -o decoder_tb
	./obj_dir/decoder_tb

clean:
	rm -rf obj_dir

// File: testbench/decoder_tb.sv
// self-checking testbench for the bit decoder; symbol strobes come from a fixed 4-clock grid
`timescale 1ns/1ns

module decoder_tb;

  import decoder_pkg::*;

  localparam int NROWS = 12;
  localparam int SETTLE = 20;
  localparam int CLK_HALF = 20;

  // ----------------------------------------------------------------------
  // stimulus table, control word and symbol count per row
  // ----------------------------------------------------------------------
  // word bits 11:10 diff, 9:8 demux, 7 biphase, 6 swap, 5 derand, 4 inv,
  // 3 clk_sel, 2 clk_inv, 1 fifo_rs, 0 spare
  localparam logic [15:0] ROW_CTRL [NROWS] = '{
    16'h0000, 16'h0408, 16'h0818, 16'h0C08, 16'h0080, 16'h0100,
    16'h0140, 16'h0200, 16'h0028, 16'h0120, 16'h0007, 16'hF2B0
  };
  localparam int ROW_SYMS [NROWS] = '{
    40, 60, 60, 40, 80, 60, 60, 60, 70, 70, 30, 60
  };

  logic        clk;
  logic        rs;
  logic        en;
  logic        wr0;
  logic        wr1;
  logic [11:0] addr;
  logic [15:0] din;
  logic        symb_en;
  logic        symb_2x_en;
  logic        symb_i;
  logic        symb_q;
  logic [15:0] dout;
  logic        dout_i;
  logic        dout_q;
  logic        bit_strobe;
  logic        fifo_rs;
  logic        clk_inv;

  // model state
  dec_ctrl_t  m_ctrl;
  logic       m_half;
  logic       m_first;
  rail_pair_t m_nrz;
  rail_pair_t m_prev;
  rail_pair_t m_dec;
  logic       m_dly;
  rail_pair_t m_sel;
  logic [DERAND_LEN-1:0] m_sr;
  logic       m_dbit;

  logic [1:0] grid;
  logic [31:0] rnd;
  int         seed;
  int         strobe_cnt;
  logic       checking;

  decoder u_decoder (
    .clk              (clk),
    .rs               (rs),
    .en_i             (en),
    .wr0_i            (wr0),
    .wr1_i            (wr1),
    .addr_i           (addr),
    .din_i            (din),
    .symb_clk_en_i    (symb_en),
    .symb_clk_2x_en_i (symb_2x_en),
    .symb_i_i         (symb_i),
    .symb_q_i         (symb_q),
    .dout_o           (dout),
    .dout_i_o         (dout_i),
    .dout_q_o         (dout_q),
    .bit_strobe_o     (bit_strobe),
    .fifo_rs_o        (fifo_rs),
    .clk_inv_o        (clk_inv)
  );

  // ----------------------------------------------------------------------
  // compare tasks
  // ----------------------------------------------------------------------
  task automatic report_mismatch(input string msg);
    $display("Fail at %0t ns: %s", $time, msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "mismatch");
  endtask

  task automatic check_reg(input logic [15:0] got, input logic [15:0] exp, input string what);
    if (got !== exp)
      report_mismatch($sformatf("%s read %h, expected %h", what, got, exp));
  endtask

  task automatic check_bits(input rail_pair_t got, input rail_pair_t exp);
    if (got !== exp)
      report_mismatch($sformatf("output pair %b, expected %b", got, exp));
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp)
      report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
  endtask

  // ----------------------------------------------------------------------
  // clock, strobe grid and random symbols
  // ----------------------------------------------------------------------
  initial
  begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  always @(posedge clk)
  begin
    #5;
    grid = grid + 2'd1;
    symb_2x_en = ~grid[0];
    symb_en = (grid == 2'd0);
    rnd = $random(seed);
    symb_i = rnd[0];
    symb_q = rnd[1];
  end

  // ----------------------------------------------------------------------
  // behavioral model, downstream stages first so each sees old values
  // ----------------------------------------------------------------------
  always @(posedge clk or posedge rs)
  begin
    logic b_en;
    logic pick;
    logic ser;
    if (rs)
    begin
      m_ctrl = '0;
      m_half = 1'b0;
      m_first = 1'b0;
      m_nrz = '0;
      m_prev = '0;
      m_dec = '0;
      m_dly = 1'b0;
      m_sel = '0;
      m_sr = '0;
      m_dbit = 1'b0;
    end
    else
    begin
      b_en = symb_en & (~m_ctrl.biphase | m_half);
      // derandomizer shifts at the bit rate of the serial stream
      if ((m_ctrl.demux_mode inside {QPSK_DEMUX, FQPSK_DEMUX}) ? symb_2x_en : symb_en)
      begin
        m_dbit = m_sel.i ^ m_sr[14] ^ m_sr[13];
        m_sr = {m_sr[13:0], m_sel.i};
      end
      if (symb_2x_en)
      begin
        pick = symb_en ^ m_ctrl.swap;
        if (m_ctrl.demux_mode == QPSK_DEMUX || m_ctrl.demux_mode == FQPSK_DEMUX)
        begin
          if (m_ctrl.demux_mode == QPSK_DEMUX)
            ser = pick ? m_dec.i : m_dec.q;
          else
            ser = m_dly ^ (pick ? m_dec.q : ~m_dec.q);
          m_sel = {~ser, ser};
        end
        else
          m_sel = m_dec;
        m_dly = m_dec.i;
      end
      if (b_en)
      begin
        case (m_ctrl.diff_mode)
          NRZ_M: m_dec = m_nrz ^ m_prev;
          NRZ_S: m_dec = ~(m_nrz ^ m_prev);
          default: m_dec = m_nrz;
        endcase
        m_prev = m_nrz;
        m_nrz.i = m_ctrl.biphase ? m_first : symb_i;
        m_nrz.q = symb_q;
      end
      if (symb_en && !m_half)
        m_first = symb_i;
      if (symb_en)
        m_half = ~m_half;
      // register takes bus writes at the same edge
      if (en && addr == DEC_CTRL_ADDR_DEFAULT)
      begin
        if (wr0)
          m_ctrl[7:0] = {din[7:1], 1'b0};
        if (wr1)
          m_ctrl[11:8] = din[11:8];
      end
    end
  end

  // outputs checked mid-cycle, well clear of the drive edge
  always @(negedge clk)
  begin
    logic exp_strobe;
    rail_pair_t exp_out;
    if (!rs && checking)
    begin
      exp_strobe = m_ctrl.biphase ? (symb_en & m_half) :
                   (m_ctrl.clk_sel ? symb_en : symb_2x_en);
      check_flag(bit_strobe, exp_strobe, "bit_strobe_o");
      if (exp_strobe)
      begin
        strobe_cnt++;
        exp_out = m_ctrl.derandomize ? {m_dbit, m_dbit} : m_sel;
        exp_out = exp_out ^ {m_ctrl.data_inv, m_ctrl.data_inv};
        check_bits({dout_i, dout_q}, exp_out);
      end
    end
  end

  // ----------------------------------------------------------------------
  // bus access
  // ----------------------------------------------------------------------
  // lanes bit 0 is the low byte, bit 1 the high byte
  task automatic write_ctrl(input logic [15:0] word, input logic [1:0] lanes);
    @(posedge clk);
    #5;
    en = 1'b1;
    wr0 = lanes[0];
    wr1 = lanes[1];
    addr = DEC_CTRL_ADDR_DEFAULT;
    din = word;
    @(posedge clk);
    #5;
    en = 1'b0;
    wr0 = 1'b0;
    wr1 = 1'b0;
    din = '0;
  endtask

  task automatic read_back(input logic [15:0] exp);
    @(posedge clk);
    #5;
    en = 1'b1;
    addr = DEC_CTRL_ADDR_DEFAULT;
    @(negedge clk);
    check_reg(dout, exp, "control register");
    @(posedge clk);
    #5;
    addr = DEC_CTRL_ADDR_DEFAULT + 12'h004;
    @(negedge clk);
    check_reg(dout, 16'h0000, "unmapped address");
    @(posedge clk);
    #5;
    en = 1'b0;
  endtask

  // watchdog sized from the table
  initial
  begin
    longint limit;
    limit = 0;
    for (int r = 0; r < NROWS; r++)
      limit += ROW_SYMS[r] + SETTLE;
    limit = limit * 4 * 2 * CLK_HALF + 200000;
    #(limit);
    $display("run exceeded the time limit without finishing");
    $display("TESTBENCH FAILED");
    $fatal(1, "timeout");
  end

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------
  initial
  begin
    seed = 32'h44077caa;
    checking = 1'b0;
    grid = 2'd3;
    rs = 1'b1;
    en = 1'b0;
    wr0 = 1'b0;
    wr1 = 1'b0;
    addr = '0;
    din = '0;
    symb_en = 1'b0;
    symb_2x_en = 1'b0;
    symb_i = 1'b0;
    symb_q = 1'b0;
    repeat (10) @(posedge clk);
    #5;
    rs = 1'b0;
    checking = 1'b1;
    read_back(16'h0000);
    check_flag(fifo_rs, 1'b0, "fifo_rs_o");
    check_flag(clk_inv, 1'b0, "clk_inv_o");
    // one lane at a time, the other byte keeps its value
    write_ctrl(16'hFFFF, 2'b01);
    read_back(16'h00FE);
    write_ctrl(16'hFFFF, 2'b10);
    read_back(16'h0FFE);
    for (int r = 0; r < NROWS; r++)
    begin
      write_ctrl(ROW_CTRL[r], 2'b11);
      read_back(ROW_CTRL[r] & 16'h0FFE);
      check_flag(fifo_rs, ROW_CTRL[r][1], "fifo_rs_o");
      check_flag(clk_inv, ROW_CTRL[r][2], "clk_inv_o");
      // settling lets the derandomizer history fill
      repeat (SETTLE * 4) @(posedge clk);
      strobe_cnt = 0;
      repeat (ROW_SYMS[r] * 4) @(posedge clk);
      if (strobe_cnt == 0)
      begin
        $display("no output strobe seen during table row %0d", r);
        $display("TESTBENCH FAILED");
        $fatal(1, "missing strobe");
      end
    end
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// File: hdl/decoder.sv
// bit decoder top; symbol strobes come from external timing recovery with no back-pressure
`timescale 1ns/1ns

module decoder
  #(
  parameter logic [11:0] CTRL_ADDR = decoder_pkg::DEC_CTRL_ADDR_DEFAULT
  )
  (
  input  logic        clk,
  input  logic        rs,
  input  logic        en_i,
  input  logic        wr0_i,
  input  logic        wr1_i,
  input  logic [11:0] addr_i,
  input  logic [15:0] din_i,
  input  logic        symb_clk_en_i,
  input  logic        symb_clk_2x_en_i,
  input  logic        symb_i_i,
  input  logic        symb_q_i,
  output logic [15:0] dout_o,
  output logic        dout_i_o,
  output logic        dout_q_o,
  output logic        bit_strobe_o,
  output logic        fifo_rs_o,
  output logic        clk_inv_o
  );

  import decoder_pkg::*;

  dec_ctrl_t  ctrl;
  logic       biphase_en;
  rail_pair_t nrz;
  rail_pair_t nrz_prev;
  rail_pair_t dec;
  rail_pair_t sel;

  // ----------------------------------------------------------------------
  // control register
  // ----------------------------------------------------------------------
  decoder_regs #(
    .CTRL_ADDR (CTRL_ADDR)
  ) u_regs (
    .clk    (clk),
    .rs     (rs),
    .en_i   (en_i),
    .wr0_i  (wr0_i),
    .wr1_i  (wr1_i),
    .addr_i (addr_i),
    .din_i  (din_i),
    .dout_o (dout_o),
    .ctrl_o (ctrl)
  );

  // straight from the register
  assign fifo_rs_o = ctrl.fifo_rs;
  assign clk_inv_o = ctrl.clk_inv;

  // ----------------------------------------------------------------------
  // pipeline
  // ----------------------------------------------------------------------

  // stage 1, biphase and i/q realignment
  biphase_to_nrz u_biphase (
    .clk           (clk),
    .rs            (rs),
    .symb_clk_en_i (symb_clk_en_i),
    .biphase_i     (ctrl.biphase),
    .symb_i_i      (symb_i_i),
    .symb_q_i      (symb_q_i),
    .biphase_en_o  (biphase_en),
    .nrz_o         (nrz),
    .nrz_prev_o    (nrz_prev)
  );

  // stage 2, one decoder per rail
  mark_space_decode u_dec_i (
    .clk          (clk),
    .rs           (rs),
    .biphase_en_i (biphase_en),
    .mode_i       (ctrl.diff_mode),
    .din_i        (nrz.i),
    .last_din_i   (nrz_prev.i),
    .dout_o       (dec.i)
  );

  mark_space_decode u_dec_q (
    .clk          (clk),
    .rs           (rs),
    .biphase_en_i (biphase_en),
    .mode_i       (ctrl.diff_mode),
    .din_i        (nrz.q),
    .last_din_i   (nrz_prev.q),
    .dout_o       (dec.q)
  );

  // stage 3, serial demux
  symbol_demux u_demux (
    .clk              (clk),
    .rs               (rs),
    .symb_clk_en_i    (symb_clk_en_i),
    .symb_clk_2x_en_i (symb_clk_2x_en_i),
    .mode_i           (ctrl.demux_mode),
    .swap_i           (ctrl.swap),
    .dec_i            (dec),
    .sel_o            (sel)
  );

  // stage 4, derandomize, invert, strobe
  bit_output_stage u_out (
    .clk              (clk),
    .rs               (rs),
    .symb_clk_en_i    (symb_clk_en_i),
    .symb_clk_2x_en_i (symb_clk_2x_en_i),
    .biphase_en_i     (biphase_en),
    .ctrl_i           (ctrl),
    .sel_i            (sel),
    .dout_i_o         (dout_i_o),
    .dout_q_o         (dout_q_o),
    .bit_strobe_o     (bit_strobe_o)
  );

endmodule

// File: hdl/bit_output_stage.sv
// x^15+x^14+1 derandomizer on the i rail and output strobe select; derandomized bits settle after 15 shifts
`timescale 1ns/1ns

module bit_output_stage
  (
  input  logic                   clk,
  input  logic                   rs,
  input  logic                   symb_clk_en_i,
  input  logic                   symb_clk_2x_en_i,
  input  logic                   biphase_en_i,
  input  decoder_pkg::dec_ctrl_t  ctrl_i,
  input  decoder_pkg::rail_pair_t sel_i,
  output logic                   dout_i_o,
  output logic                   dout_q_o,
  output logic                   bit_strobe_o
  );

  import decoder_pkg::*;

  logic                  demux_on;
  logic                  shift_en;
  logic [DERAND_LEN-1:0] derand_sr;
  logic                  derand_bit;
  rail_pair_t            pre_inv;

  // ----------------------------------------------------------------------
  // derandomizer
  // ----------------------------------------------------------------------

  // serial modes run at twice the symbol rate
  assign demux_on = (ctrl_i.demux_mode == QPSK_DEMUX) ||
                    (ctrl_i.demux_mode == FQPSK_DEMUX);
  assign shift_en = demux_on ? symb_clk_2x_en_i : symb_clk_en_i;

  // self-synchronizing, taps 14 and 13
  always_ff @(posedge clk or posedge rs)
  begin
    if (rs)
    begin
      derand_sr  <= '0;
      derand_bit <= 1'b0;
    end
    else if (shift_en)
    begin
      derand_sr  <= {derand_sr[DERAND_LEN-2:0], sel_i.i};
      derand_bit <= sel_i.i ^ derand_sr[DERAND_LEN-1] ^ derand_sr[DERAND_LEN-2];
    end
  end

  // ----------------------------------------------------------------------
  // output formatting
  // ----------------------------------------------------------------------

  // both rails carry the single derandomized stream
  assign pre_inv  = ctrl_i.derandomize ? {derand_bit, derand_bit} : sel_i;
  assign dout_i_o = pre_inv.i ^ ctrl_i.data_inv;
  assign dout_q_o = pre_inv.q ^ ctrl_i.data_inv;

  // strobe follows the bit rate in use
  assign bit_strobe_o = ctrl_i.biphase ? biphase_en_i :
                        (ctrl_i.clk_sel ? symb_clk_en_i : symb_clk_2x_en_i);

  // pair strobe from stage 1 still sits on the 2x grid
  a_strobe_on_2x : assert property (@(posedge clk) disable iff (rs)
    bit_strobe_o |-> symb_clk_2x_en_i);

endmodule

// File: hdl/symbol_demux.sv
// QPSK/OQPSK and FQPSK serial demux; symb_clk_en must coincide with a 2x pulse
`timescale 1ns/1ns

module symbol_demux
  (
  input  logic                    clk,
  input  logic                    rs,
  input  logic                    symb_clk_en_i,
  input  logic                    symb_clk_2x_en_i,
  input  decoder_pkg::demux_mode_e mode_i,
  input  logic                    swap_i,
  input  decoder_pkg::rail_pair_t  dec_i,
  output decoder_pkg::rail_pair_t  sel_o
  );

  import decoder_pkg::*;

  logic phase;
  logic pick_i;
  logic dec_dly_i;
  logic qpsk_bit;
  logic fqpsk_bit;

  // ----------------------------------------------------------------------
  // half-symbol phase
  // ----------------------------------------------------------------------

  // 1 on the 2x pulse shared with the symbol strobe
  // 0 on the mid-symbol pulse
  assign phase = symb_clk_en_i;

  // swap flips which half gets the i rail
  assign pick_i = phase ^ swap_i;

  // ----------------------------------------------------------------------
  // serial streams
  // ----------------------------------------------------------------------

  // plain interleave
  assign qpsk_bit = pick_i ? dec_i.i : dec_i.q;

  // i from the previous half, for the cross-rail difference
  always_ff @(posedge clk or posedge rs)
  begin
    if (rs)
    begin
      dec_dly_i <= 1'b0;
    end
    else if (symb_clk_2x_en_i)
    begin
      dec_dly_i <= dec_i.i;
    end
  end

  // fqpsk cross-rail rule
  assign fqpsk_bit = pick_i ? (dec_dly_i ^ dec_i.q) : (dec_dly_i ^ ~dec_i.q);

  // ----------------------------------------------------------------------
  // output select
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or posedge rs)
  begin
    if (rs)
    begin
      sel_o <= '0;
    end
    else if (symb_clk_2x_en_i)
    begin
      case (mode_i)
        QPSK_DEMUX:
        begin
          sel_o.i <= ~qpsk_bit;
          sel_o.q <= qpsk_bit;
        end
        FQPSK_DEMUX:
        begin
          sel_o.i <= ~fqpsk_bit;
          sel_o.q <= fqpsk_bit;
        end
        // parallel and the unused code
        default: sel_o <= dec_i;
      endcase
    end
  end

  // strobe nesting from the timing recovery
  a_symb_in_2x : assert property (@(posedge clk) disable iff (rs)
    symb_clk_en_i |-> symb_clk_2x_en_i);

endmodule

// File: hdl/mark_space_decode.sv
// one rail of NRZ-L/M/S decoding; the RESERVED code decodes as NRZ-L
`timescale 1ns/1ns

module mark_space_decode
  (
  input  logic                   clk,
  input  logic                   rs,
  input  logic                   biphase_en_i,
  input  decoder_pkg::diff_mode_e mode_i,
  input  logic                   din_i,
  input  logic                   last_din_i,
  output logic                   dout_o
  );

  import decoder_pkg::*;

  logic trans;
  logic dec_bit;

  // a transition between consecutive bits
  assign trans = din_i ^ last_din_i;

  // ----------------------------------------------------------------------
  // decode rule
  // ----------------------------------------------------------------------
  always_comb
  begin
    case (mode_i)
      // mark, 1 on a transition
      NRZ_M: dec_bit = trans;
      // space, 1 when the level holds
      NRZ_S: dec_bit = ~trans;
      // level, RESERVED included
      default: dec_bit = din_i;
    endcase
  end

  // one pair strobe of delay
  always_ff @(posedge clk or posedge rs)
  begin
    if (rs)
    begin
      dout_o <= 1'b0;
    end
    else if (biphase_en_i)
    begin
      dout_o <= dec_bit;
    end
  end

endmodule

// File: hdl/biphase_to_nrz.sv
// biphase-L to NRZ on I; pair alignment is fixed at reset and the second half of a pair is ignored
`timescale 1ns/1ns

module biphase_to_nrz
  (
  input  logic                   clk,
  input  logic                   rs,
  input  logic                   symb_clk_en_i,
  input  logic                   biphase_i,
  input  logic                   symb_i_i,
  input  logic                   symb_q_i,
  output logic                   biphase_en_o,
  output decoder_pkg::rail_pair_t nrz_o,
  output decoder_pkg::rail_pair_t nrz_prev_o
  );

  logic half_q;
  logic first_half_q;
  logic nrz_i_src;

  // ----------------------------------------------------------------------
  // pair strobe
  // ----------------------------------------------------------------------

  // half counter runs from reset
  // 0 marks the first half of a pair
  always_ff @(posedge clk or posedge rs)
  begin
    if (rs)
    begin
      half_q <= 1'b0;
    end
    else if (symb_clk_en_i)
    begin
      half_q <= ~half_q;
    end
  end

  // every symbol without biphase
  // only on the second half with biphase
  assign biphase_en_o = symb_clk_en_i & (~biphase_i | half_q);

  // first half of the pair carries the bit
  always_ff @(posedge clk)
  begin
    if (symb_clk_en_i && !half_q)
    begin
      first_half_q <= symb_i_i;
    end
  end

  assign nrz_i_src = biphase_i ? first_half_q : symb_i_i;

  // ----------------------------------------------------------------------
  // nrz stage and history
  // ----------------------------------------------------------------------

  // q also takes one pair strobe
  // keeps i and q aligned
  always_ff @(posedge clk or posedge rs)
  begin
    if (rs)
    begin
      nrz_o      <= '0;
      nrz_prev_o <= '0;
    end
    else if (biphase_en_o)
    begin
      nrz_o.i    <= nrz_i_src;
      nrz_o.q    <= symb_q_i;
      // previous pair for mark/space decode
      nrz_prev_o <= nrz_o;
    end
  end

endmodule

// File: hdl/decoder_regs.sv
// control register; bits 15:12 and the spare bit read 0, and a read outside CTRL_ADDR returns 0
`timescale 1ns/1ns

module decoder_regs
  #(
  parameter logic [11:0] CTRL_ADDR = decoder_pkg::DEC_CTRL_ADDR_DEFAULT
  )
  (
  input  logic                  clk,
  input  logic                  rs,
  input  logic                  en_i,
  input  logic                  wr0_i,
  input  logic                  wr1_i,
  input  logic [11:0]           addr_i,
  input  logic [15:0]           din_i,
  output logic [15:0]           dout_o,
  output decoder_pkg::dec_ctrl_t ctrl_o
  );

  import decoder_pkg::*;

  dec_ctrl_t ctrl_q;
  logic      hit;

  // address qualified access
  assign hit = en_i && (addr_i == CTRL_ADDR);

  // ----------------------------------------------------------------------
  // byte lane writes
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or posedge rs)
  begin
    if (rs)
    begin
      ctrl_q <= '0;
    end
    else
    begin
      // low lane, spare bit kept at zero
      if (hit && wr0_i)
      begin
        ctrl_q[7:0] <= {din_i[7:1], 1'b0};
      end
      // high lane holds only 4 real bits
      if (hit && wr1_i)
      begin
        ctrl_q[11:8] <= din_i[11:8];
      end
    end
  end

  // readback, upper nibble always zero
  assign dout_o = hit ? {4'h0, ctrl_q} : 16'h0000;
  assign ctrl_o = ctrl_q;

  // write strobes only inside an enabled cycle
  a_wr_needs_en : assert property (@(posedge clk) disable iff (rs)
    (wr0_i || wr1_i) |-> en_i);

endmodule

// File: hdl/decoder_pkg.sv
// shared types for the bit decoder; the control word is 12 bits and its spare bit always reads 0

package decoder_pkg;

  // ----------------------------------------------------------------------
  // mode encodings
  // ----------------------------------------------------------------------

  // differential decoding per rail
  // RESERVED falls back to NRZ_L in the decoder
  typedef enum logic [1:0] {
    NRZ_L    = 2'd0,
    NRZ_M    = 2'd1,
    NRZ_S    = 2'd2,
    RESERVED = 2'd3
  } diff_mode_e;

  // output arrangement
  // code 3 is unused and behaves as PARALLEL
  typedef enum logic [1:0] {
    PARALLEL    = 2'd0,
    QPSK_DEMUX  = 2'd1,
    FQPSK_DEMUX = 2'd2
  } demux_mode_e;

  // ----------------------------------------------------------------------
  // control word, msb first
  // ----------------------------------------------------------------------
  typedef struct packed {
    diff_mode_e  diff_mode;
    demux_mode_e demux_mode;
    logic        biphase;
    logic        swap;
    logic        derandomize;
    logic        data_inv;
    logic        clk_sel;
    logic        clk_inv;
    logic        fifo_rs;
    logic        spare;
  } dec_ctrl_t;

  // one bit on each rail
  typedef struct packed {
    logic i;
    logic q;
  } rail_pair_t;

  // bus address of the control register
  localparam logic [11:0] DEC_CTRL_ADDR_DEFAULT = 12'h040;

  // derandomizer length for x^15+x^14+1
  localparam int DERAND_LEN = 15;

endpackage
